//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // datapath and register file widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;

    // first fetch after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000;

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } op_t;

    // function field of SPECIAL, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    // operations carried from decode into execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_t;

endpackage

`default_nettype wire

//--- verilog/regfile.sv
`default_nettype none

module regfile import cpu_pkg::*; (
    input  wire                  aclk,
    input  wire [REG_ADDR_W-1:0] rf_raddr1,
    input  wire [REG_ADDR_W-1:0] rf_raddr2,
    input  wire                  rf_we,
    input  wire [REG_ADDR_W-1:0] rf_waddr,
    input  wire [XLEN-1:0]       rf_wdata,
    output logic [XLEN-1:0]      rf_rdata1,
    output logic [XLEN-1:0]      rf_rdata2
);

    logic [XLEN-1:0] regs [0:(1 << REG_ADDR_W)-1];

    always_ff @(posedge aclk) begin
        if (rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // r0 is hardwired, the array entry is never read
    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : regs[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : regs[rf_raddr2];

    // writeback must filter r0 before it reaches the array
    a_no_r0_write: assert property (@(posedge aclk)
        rf_we |-> rf_waddr != '0);

endmodule

`default_nettype wire

//--- verilog/if_stage.sv
`default_nettype none

module if_stage import cpu_pkg::*; (
    input  wire               aclk,
    input  wire               rst_n,
    input  wire               inst_ready,
    input  wire [INST_W-1:0]  inst_rdata,
    input  wire               br_taken,
    input  wire [XLEN-1:0]    br_target,
    output logic              inst_req,
    output logic [XLEN-1:0]   inst_addr,
    output logic              fs_valid,
    output logic [XLEN-1:0]   fs_pc,
    output logic [INST_W-1:0] fs_inst
);

    logic            fetch_en;
    logic            fetch_fire;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;
    logic            br_pend;
    logic [XLEN-1:0] br_pend_target;

    assign inst_req   = fetch_en;
    assign inst_addr  = pc;
    assign fetch_fire = inst_req && inst_ready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    // the fetch accepted with br_taken is the delay slot
    always_comb begin
        if (br_taken) begin
            pc_next = br_target;
        end else if (br_pend) begin
            pc_next = br_pend_target;
        end else begin
            pc_next = pc + XLEN'(4);
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (fetch_fire) begin
            pc <= pc_next;
        end
    end

    // target seen during a stall waits for the delay slot fetch
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            br_pend <= 1'b0;
        end else if (br_taken && !fetch_fire) begin
            br_pend <= 1'b1;
        end else if (fetch_fire) begin
            br_pend <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (br_taken && !fetch_fire) begin
            br_pend_target <= br_target;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            fs_valid <= 1'b0;
        end else begin
            fs_valid <= fetch_fire;
        end
    end

    always_ff @(posedge aclk) begin
        if (fetch_fire) begin
            fs_pc   <= pc;
            fs_inst <= inst_rdata;
        end
    end

    a_addr_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        inst_req && !inst_ready |=> $stable(inst_addr));

endmodule

`default_nettype wire

//--- verilog/id_stage.sv
`default_nettype none

module id_stage import cpu_pkg::*; (
    input  wire                   aclk,
    input  wire                   rst_n,
    input  wire                   fs_valid,
    input  wire [XLEN-1:0]        fs_pc,
    input  wire [INST_W-1:0]      fs_inst,
    input  wire                   es_fwd_valid,
    input  wire [REG_ADDR_W-1:0]  es_dest,
    input  wire [XLEN-1:0]        es_result,
    input  wire                   rf_we,
    input  wire [REG_ADDR_W-1:0]  rf_waddr,
    input  wire [XLEN-1:0]        rf_wdata,
    output logic                  br_taken,
    output logic [XLEN-1:0]       br_target,
    output logic                  ds_valid,
    output logic [XLEN-1:0]       ds_pc,
    output alu_op_t               ds_alu_op,
    output logic [XLEN-1:0]       ds_src_a,
    output logic [XLEN-1:0]       ds_src_b,
    output logic [REG_ADDR_W-1:0] ds_dest,
    output logic                  ds_wen
);

    op_t                   op;
    funct_t                funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic [XLEN-1:0]       rs_val;
    logic [XLEN-1:0]       rt_val;
    logic [XLEN-1:0]       sext_imm;
    logic [XLEN-1:0]       zext_imm;
    logic [XLEN-1:0]       shamt;
    logic [XLEN-1:0]       pc_plus4;
    logic                  is_beq;
    logic                  is_bne;
    logic                  is_j;

    assign op       = op_t'(fs_inst[31:26]);
    assign funct    = funct_t'(fs_inst[5:0]);
    assign rs       = fs_inst[25:21];
    assign rt       = fs_inst[20:16];
    assign rd       = fs_inst[15:11];
    assign sext_imm = {{(XLEN-16){fs_inst[15]}}, fs_inst[15:0]};
    assign zext_imm = {{(XLEN-16){1'b0}}, fs_inst[15:0]};
    assign shamt    = XLEN'(fs_inst[10:6]);
    assign pc_plus4 = fs_pc + XLEN'(4);

    regfile u_regfile (
        .aclk      (aclk),
        .rf_raddr1 (rs),
        .rf_raddr2 (rt),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2)
    );

    // newest value wins: execute, then writeback, then the array
    function automatic logic [XLEN-1:0] bypass(
        input logic [REG_ADDR_W-1:0] raddr,
        input logic [XLEN-1:0]       rf_val
    );
        if (raddr == '0) begin
            bypass = '0;
        end else if (es_fwd_valid && es_dest == raddr) begin
            bypass = es_result;
        end else if (rf_we && rf_waddr == raddr) begin
            bypass = rf_wdata;
        end else begin
            bypass = rf_val;
        end
    endfunction

    always_comb begin
        rs_val = bypass(rs, rf_rdata1);
        rt_val = bypass(rt, rf_rdata2);
    end

    always_comb begin
        ds_alu_op = ALU_ADD;
        ds_src_a  = rs_val;
        ds_src_b  = rt_val;
        ds_dest   = rd;
        ds_wen    = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (op)
            OP_SPECIAL: begin
                ds_wen = 1'b1;
                case (funct)
                    FN_ADDU: ds_alu_op = ALU_ADD;
                    FN_SUBU: ds_alu_op = ALU_SUB;
                    FN_AND:  ds_alu_op = ALU_AND;
                    FN_OR:   ds_alu_op = ALU_OR;
                    FN_XOR:  ds_alu_op = ALU_XOR;
                    FN_NOR:  ds_alu_op = ALU_NOR;
                    FN_SLT:  ds_alu_op = ALU_SLT;
                    FN_SLTU: ds_alu_op = ALU_SLTU;
                    FN_SLL: begin
                        ds_alu_op = ALU_SLL;
                        ds_src_a  = shamt;
                    end
                    FN_SRL: begin
                        ds_alu_op = ALU_SRL;
                        ds_src_a  = shamt;
                    end
                    default: ds_wen = 1'b0;
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ds_wen   = 1'b1;
                ds_dest  = rt;
                ds_src_b = (op == OP_ADDIU) ? sext_imm : zext_imm;
                case (op)
                    OP_ANDI: ds_alu_op = ALU_AND;
                    OP_ORI:  ds_alu_op = ALU_OR;
                    OP_XORI: ds_alu_op = ALU_XOR;
                    OP_LUI:  ds_alu_op = ALU_LUI;
                    default: ds_alu_op = ALU_ADD;
                endcase
            end
            OP_BEQ:  is_beq = 1'b1;
            OP_BNE:  is_bne = 1'b1;
            OP_J:    is_j   = 1'b1;
            default: ds_wen = 1'b0;
        endcase
    end

    // targets are relative to the delay slot
    assign br_target = is_j ? {pc_plus4[XLEN-1:28], fs_inst[25:0], 2'b00}
                            : pc_plus4 + {sext_imm[XLEN-3:0], 2'b00};

    assign br_taken = fs_valid && (is_j || (is_beq && rs_val == rt_val)
                                        || (is_bne && rs_val != rt_val));

    assign ds_valid = fs_valid;
    assign ds_pc    = fs_pc;

    // redirect is a single pulse, no branch sits in a delay slot
    a_br_one_cycle: assert property (@(posedge aclk) disable iff (!rst_n)
        br_taken |=> !br_taken);

endmodule

`default_nettype wire

//--- verilog/exe_stage.sv
`default_nettype none

module exe_stage import cpu_pkg::*; (
    input  wire                   aclk,
    input  wire                   rst_n,
    input  wire                   ds_valid,
    input  wire [XLEN-1:0]        ds_pc,
    input  wire alu_op_t          ds_alu_op,
    input  wire [XLEN-1:0]        ds_src_a,
    input  wire [XLEN-1:0]        ds_src_b,
    input  wire [REG_ADDR_W-1:0]  ds_dest,
    input  wire                   ds_wen,
    output logic                  es_fwd_valid,
    output logic                  es_valid,
    output logic [XLEN-1:0]       es_pc,
    output logic [XLEN-1:0]       es_result,
    output logic [REG_ADDR_W-1:0] es_dest,
    output logic                  es_wen
);

    alu_op_t         ex_alu_op;
    logic [XLEN-1:0] ex_src_a;
    logic [XLEN-1:0] ex_src_b;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            es_valid <= 1'b0;
        end else begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (ds_valid) begin
            es_pc     <= ds_pc;
            ex_alu_op <= ds_alu_op;
            ex_src_a  <= ds_src_a;
            ex_src_b  <= ds_src_b;
            es_dest   <= ds_dest;
            es_wen    <= ds_wen;
        end
    end

    // shift amount sits in src_a, the shifted value in src_b
    always_comb begin
        case (ex_alu_op)
            ALU_ADD:  es_result = ex_src_a + ex_src_b;
            ALU_SUB:  es_result = ex_src_a - ex_src_b;
            ALU_AND:  es_result = ex_src_a & ex_src_b;
            ALU_OR:   es_result = ex_src_a | ex_src_b;
            ALU_XOR:  es_result = ex_src_a ^ ex_src_b;
            ALU_NOR:  es_result = ~(ex_src_a | ex_src_b);
            ALU_SLT:  es_result = XLEN'($signed(ex_src_a) < $signed(ex_src_b));
            ALU_SLTU: es_result = XLEN'(ex_src_a < ex_src_b);
            ALU_SLL:  es_result = ex_src_b << ex_src_a[4:0];
            ALU_SRL:  es_result = ex_src_b >> ex_src_a[4:0];
            ALU_LUI:  es_result = {ex_src_b[15:0], 16'h0000};
            default:  es_result = '0;
        endcase
    end

    // decode only looks at dest and result once this is high
    assign es_fwd_valid = es_valid && es_wen;

    a_alu_op_known: assert property (@(posedge aclk) disable iff (!rst_n)
        ds_valid |-> ds_alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                       ALU_NOR, ALU_SLT, ALU_SLTU, ALU_SLL,
                                       ALU_SRL, ALU_LUI});

endmodule

`default_nettype wire

//--- verilog/wb_stage.sv
`default_nettype none

module wb_stage import cpu_pkg::*; (
    input  wire                   aclk,
    input  wire                   rst_n,
    input  wire                   es_valid,
    input  wire [XLEN-1:0]        es_pc,
    input  wire [XLEN-1:0]        es_result,
    input  wire [REG_ADDR_W-1:0]  es_dest,
    input  wire                   es_wen,
    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic [XLEN-1:0]       rf_wdata,
    output logic [XLEN-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_wen,
    output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [XLEN-1:0]       debug_wb_rf_wdata
);

    logic                  ws_valid;
    logic [XLEN-1:0]       ws_pc;
    logic [XLEN-1:0]       ws_result;
    logic [REG_ADDR_W-1:0] ws_dest;
    logic                  ws_wen;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= es_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (es_valid) begin
            ws_pc     <= es_pc;
            ws_result <= es_result;
            ws_dest   <= es_dest;
            ws_wen    <= es_wen;
        end
    end

    // r0 targets are dropped here, so they leave no trace either
    assign rf_we    = ws_valid && ws_wen && (ws_dest != '0);
    assign rf_waddr = ws_dest;
    assign rf_wdata = ws_result;

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = ws_result;

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire                   aclk,
    input  wire                   rst_n,
    input  wire                   inst_ready,
    input  wire [INST_W-1:0]      inst_rdata,
    output wire                   inst_req,
    output wire [XLEN-1:0]        inst_addr,
    output wire [XLEN-1:0]        debug_wb_pc,
    output wire [3:0]             debug_wb_rf_wen,
    output wire [REG_ADDR_W-1:0]  debug_wb_rf_wnum,
    output wire [XLEN-1:0]        debug_wb_rf_wdata
);

    // fetch to decode
    wire                  fs_valid;
    wire [XLEN-1:0]       fs_pc;
    wire [INST_W-1:0]     fs_inst;
    wire                  br_taken;
    wire [XLEN-1:0]       br_target;

    // decode to execute
    wire                  ds_valid;
    wire [XLEN-1:0]       ds_pc;
    wire alu_op_t         ds_alu_op;
    wire [XLEN-1:0]       ds_src_a;
    wire [XLEN-1:0]       ds_src_b;
    wire [REG_ADDR_W-1:0] ds_dest;
    wire                  ds_wen;

    // execute to writeback, also bypassed into decode
    wire                  es_fwd_valid;
    wire                  es_valid;
    wire [XLEN-1:0]       es_pc;
    wire [XLEN-1:0]       es_result;
    wire [REG_ADDR_W-1:0] es_dest;
    wire                  es_wen;

    // register file write port
    wire                  rf_we;
    wire [REG_ADDR_W-1:0] rf_waddr;
    wire [XLEN-1:0]       rf_wdata;

    if_stage u_if_stage (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .inst_ready (inst_ready),
        .inst_rdata (inst_rdata),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .inst_req   (inst_req),
        .inst_addr  (inst_addr),
        .fs_valid   (fs_valid),
        .fs_pc      (fs_pc),
        .fs_inst    (fs_inst)
    );

    id_stage u_id_stage (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .fs_valid     (fs_valid),
        .fs_pc        (fs_pc),
        .fs_inst      (fs_inst),
        .es_fwd_valid (es_fwd_valid),
        .es_dest      (es_dest),
        .es_result    (es_result),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .ds_valid     (ds_valid),
        .ds_pc        (ds_pc),
        .ds_alu_op    (ds_alu_op),
        .ds_src_a     (ds_src_a),
        .ds_src_b     (ds_src_b),
        .ds_dest      (ds_dest),
        .ds_wen       (ds_wen)
    );

    exe_stage u_exe_stage (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .ds_valid     (ds_valid),
        .ds_pc        (ds_pc),
        .ds_alu_op    (ds_alu_op),
        .ds_src_a     (ds_src_a),
        .ds_src_b     (ds_src_b),
        .ds_dest      (ds_dest),
        .ds_wen       (ds_wen),
        .es_fwd_valid (es_fwd_valid),
        .es_valid     (es_valid),
        .es_pc        (es_pc),
        .es_result    (es_result),
        .es_dest      (es_dest),
        .es_wen       (es_wen)
    );

    wb_stage u_wb_stage (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .es_valid          (es_valid),
        .es_pc             (es_pc),
        .es_result         (es_result),
        .es_dest           (es_dest),
        .es_wen            (es_wen),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

//--- tb/tb_cpu_top.sv
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN      = 30;
    localparam int EXP_LEN       = 21;
    localparam int TRACE_TIMEOUT = 200;
    localparam int DRAIN_CYCLES  = 30;

    logic        aclk = 1'b0;
    logic        rst_n;
    logic        inst_ready = 1'b0;
    logic [31:0] inst_rdata = 32'h0;
    wire         inst_req;
    wire  [31:0] inst_addr;
    wire  [31:0] debug_wb_pc;
    wire  [3:0]  debug_wb_rf_wen;
    wire  [4:0]  debug_wb_rf_wnum;
    wire  [31:0] debug_wb_rf_wdata;

    // program words and the trace they must produce
    logic [31:0] prog [0:PROG_LEN-1];
    logic [31:0] exp_pc [0:EXP_LEN-1];
    logic [4:0]  exp_num [0:EXP_LEN-1];
    logic [31:0] exp_data [0:EXP_LEN-1];
    int          exp_count;

    logic        stall_en;
    logic [15:0] lfsr = 16'd13;
    logic        timed_out;
    int          value_errors;
    int          timeout_errors;
    int          other_errors;

    cpu_top uut (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .inst_ready        (inst_ready),
        .inst_rdata        (inst_rdata),
        .inst_req          (inst_req),
        .inst_addr         (inst_addr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #4 aclk = ~aclk;

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input logic [5:0] funct);
        r_type = {6'h00, rs, rt, rd, sa, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        i_type = {op, rs, rt, imm};
    endfunction

    // upper four bits come from the delay slot pc
    function automatic logic [31:0] j_type(input logic [31:0] target);
        j_type = {6'h02, target[27:2]};
    endfunction

    function automatic logic [31:0] pc_of(input int idx);
        pc_of = RESET_PC + 32'(idx * 4);
    endfunction

    // right-shift galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            lfsr_next = (state >> 1) ^ 16'hb400;
        end else begin
            lfsr_next = state >> 1;
        end
    endfunction

    // nop past the end of the program
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - RESET_PC;
        if (offset[1:0] == 2'b00 && offset < 32'(PROG_LEN * 4)) begin
            word_at = prog[int'(offset >> 2)];
        end else begin
            word_at = 32'h0;
        end
    endfunction

    task automatic add_expect(input int idx, input logic [4:0] num, input logic [31:0] data);
        exp_pc[exp_count]   = pc_of(idx);
        exp_num[exp_count]  = num;
        exp_data[exp_count] = data;
        exp_count++;
    endtask

    task automatic load_tables();
        prog[0]  = i_type(OP_LUI, 0, 1, 16'h1234);
        prog[1]  = i_type(OP_ORI, 1, 1, 16'h5678);
        prog[2]  = i_type(OP_ADDIU, 0, 2, 16'hffff);
        prog[3]  = r_type(1, 2, 3, 0, FN_ADDU);
        prog[4]  = r_type(3, 1, 4, 0, FN_SUBU);
        prog[5]  = r_type(1, 2, 5, 0, FN_AND);
        prog[6]  = r_type(1, 3, 6, 0, FN_XOR);
        prog[7]  = r_type(1, 0, 7, 0, FN_NOR);
        prog[8]  = r_type(2, 1, 8, 0, FN_SLT);
        prog[9]  = r_type(2, 1, 9, 0, FN_SLTU);
        prog[10] = r_type(0, 1, 10, 4, FN_SLL);
        prog[11] = r_type(0, 1, 11, 8, FN_SRL);
        prog[12] = i_type(OP_ANDI, 7, 12, 16'hff00);
        prog[13] = i_type(OP_XORI, 1, 13, 16'hffff);
        // r0 write, then r0 read right behind it
        prog[14] = i_type(OP_ADDIU, 1, 0, 16'h0005);
        prog[15] = i_type(OP_ADDIU, 0, 14, 16'h0007);
        // beq taken to 19, 18 skipped
        prog[16] = i_type(OP_BEQ, 1, 5, 16'h0002);
        prog[17] = i_type(OP_ADDIU, 0, 15, 16'h0001);
        prog[18] = i_type(OP_ADDIU, 0, 16, 16'h0002);
        prog[19] = i_type(OP_BNE, 1, 5, 16'h0002);
        prog[20] = i_type(OP_ADDIU, 0, 17, 16'h0003);
        prog[21] = i_type(OP_BEQ, 1, 2, 16'h0005);
        prog[22] = i_type(OP_ADDIU, 0, 18, 16'h0004);
        // bne on a bypassed operand, taken to 26
        prog[23] = i_type(OP_BNE, 18, 2, 16'h0002);
        prog[24] = i_type(OP_ADDIU, 0, 19, 16'h0005);
        prog[25] = i_type(OP_ADDIU, 0, 20, 16'h0006);
        prog[26] = j_type(pc_of(29));
        prog[27] = i_type(OP_ADDIU, 0, 21, 16'h0007);
        prog[28] = i_type(OP_ADDIU, 0, 22, 16'h0008);
        prog[29] = i_type(OP_ADDIU, 21, 23, 16'h0001);

        add_expect(0, 1, 32'h1234_0000);
        add_expect(1, 1, 32'h1234_5678);
        add_expect(2, 2, 32'hffff_ffff);
        add_expect(3, 3, 32'h1234_5677);
        add_expect(4, 4, 32'hffff_ffff);
        add_expect(5, 5, 32'h1234_5678);
        add_expect(6, 6, 32'h0000_000f);
        add_expect(7, 7, 32'hedcb_a987);
        add_expect(8, 8, 32'h0000_0001);
        add_expect(9, 9, 32'h0000_0000);
        add_expect(10, 10, 32'h2345_6780);
        add_expect(11, 11, 32'h0012_3456);
        add_expect(12, 12, 32'h0000_a900);
        add_expect(13, 13, 32'h1234_a987);
        add_expect(15, 14, 32'h0000_0007);
        add_expect(17, 15, 32'h0000_0001);
        add_expect(20, 17, 32'h0000_0003);
        add_expect(22, 18, 32'h0000_0004);
        add_expect(24, 19, 32'h0000_0005);
        add_expect(27, 21, 32'h0000_0007);
        add_expect(29, 23, 32'h0000_0008);
    endtask

    // fetch port, pc only moves at the rising edge
    always @(negedge aclk) begin
        if (stall_en) begin
            inst_ready = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end else begin
            inst_ready = 1'b1;
            lfsr = 16'd13;
        end
        inst_rdata = word_at(inst_addr);
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic wait_for_trace(input int entry);
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (debug_wb_rf_wen == 4'h0 && cycles < TRACE_TIMEOUT) begin
            @(negedge aclk);
            cycles++;
        end
        if (debug_wb_rf_wen == 4'h0) begin
            $display("timeout: trace entry %0d (pc %h) did not retire within %0d cycles",
                     entry, exp_pc[entry], TRACE_TIMEOUT);
            timeout_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_program(input logic use_stalls);
        int entry;
        $display("program run, random fetch stalls %0d", use_stalls);
        @(posedge aclk);
        stall_en = use_stalls;
        @(negedge aclk);
        rst_n = 1'b0;
        repeat (3) @(negedge aclk);
        rst_n = 1'b1;
        @(negedge aclk);
        compare_field("inst_addr", inst_addr, RESET_PC);
        compare_field("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'h0);
        if (inst_req !== 1'b1) begin
            $display("inst_req is not high in the first cycle after reset");
            other_errors++;
        end
        entry = 0;
        while (entry < exp_count && !timed_out) begin
            wait_for_trace(entry);
            if (!timed_out) begin
                compare_field("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'hf);
                compare_field("debug_wb_pc", debug_wb_pc, exp_pc[entry]);
                compare_field("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(exp_num[entry]));
                compare_field("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data[entry]);
            end
            entry++;
        end
        // only nops follow, nothing else may retire
        if (!timed_out) begin
            repeat (DRAIN_CYCLES) begin
                @(negedge aclk);
                if (debug_wb_rf_wen != 4'h0) begin
                    $display("unexpected trace entry at pc %h after the program end",
                             debug_wb_pc);
                    other_errors++;
                end
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        stall_en = 1'b0;
        timed_out = 1'b0;
        value_errors = 0;
        timeout_errors = 0;
        other_errors = 0;
        exp_count = 0;
        load_tables();
        run_program(1'b0);
        if (!timed_out) begin
            run_program(1'b1);
        end
        $display("value errors %0d, timeouts %0d, other errors %0d",
                 value_errors, timeout_errors, other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
verilog/cpu_pkg.sv
verilog/regfile.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/exe_stage.sv
verilog/wb_stage.sv
verilog/cpu_top.sv
tb/tb_cpu_top.sv

//--- run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_cpu_top -f all.f -o sim_tb || exit 1

out=$(./obj_dir/sim_tb)
echo "$out"

echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1
